//--- files.f
verilog/dccm_pkg.sv
verilog/ic_tag_pkg.sv
verilog/sram_1p.sv
verilog/dccm_error_inject.sv
verilog/veer_sram_export.sv
bench/tb_clock_gen.sv
bench/veer_sram_export_assertions.sv
bench/veer_sram_export_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory export testbench with Verilator.
# The exit status is the simulation's pass or fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
        --top-module veer_sram_export_tb -Mdir obj_dir -o sim \
        && ./obj_dir/sim \
        || exit 1

//--- bench/sram_vectors.hex
// op sel addr data ecc inj exp_data exp_ecc, one record per line
// op 1 wr 2 rd 3 arm 4 tag wr 5 tag rd 6 multi wr 7 pending 8 dccm hold 9 tag hold
01 0 10 11111111 01 00 00000000 00
02 0 10 00000000 00 00 11111111 01
01 1 10 22222222 02 00 00000000 00
02 1 10 00000000 00 00 22222222 02
01 2 10 33333333 03 00 00000000 00
02 2 10 00000000 00 00 33333333 03
01 3 10 44444444 04 00 00000000 00
02 3 10 00000000 00 00 44444444 04
01 0 ff deadbeef 7f 00 00000000 00
02 0 ff 00000000 00 00 deadbeef 7f
02 0 10 00000000 00 00 11111111 01
02 1 10 00000000 00 00 22222222 02
02 2 10 00000000 00 00 33333333 03
02 3 10 00000000 00 00 44444444 04
07 0 00 00000000 00 00 00000000 00
03 0 00 00000000 00 85 00000000 00
07 0 00 00000000 00 00 00000001 00
01 2 20 12345678 2a 00 00000000 00
07 0 00 00000000 00 00 00000000 00
02 2 20 00000000 00 00 12345658 2a
01 2 21 12345678 2a 00 00000000 00
02 2 21 00000000 00 00 12345678 2a
03 0 00 00000000 00 a3 00000000 00
01 3 30 cafef00d 2a 00 00000000 00
02 3 30 00000000 00 00 cafef00d 22
07 0 00 00000000 00 00 00000000 00
03 0 00 00000000 00 e6 00000000 00
07 0 00 00000000 00 00 00000001 00
06 6 40 a5a5a5a5 11 00 00000000 00
07 0 00 00000000 00 00 00000000 00
02 1 40 00000000 00 00 a5a5a5a4 51
02 2 40 00000000 00 00 a5a5a5a5 11
03 0 00 00000000 00 80 00000000 00
03 0 00 00000000 00 81 00000000 00
01 0 50 00000000 00 00 00000000 00
02 0 50 00000000 00 00 00000001 00
04 0 05 00123456 00 00 00000000 00
04 1 05 02abcdef 00 00 00000000 00
05 0 05 00000000 00 00 00123456 00
05 1 05 00000000 00 00 02abcdef 00
04 1 3f 03ffffff 00 00 00000000 00
05 1 3f 00000000 00 00 03ffffff 00
05 0 05 00000000 00 00 00123456 00
02 0 10 00000000 00 00 11111111 01
01 0 10 99999999 09 00 00000000 00
08 0 00 00000000 00 00 11111111 01
02 0 10 00000000 00 00 99999999 09
05 0 05 00000000 00 00 00123456 00
04 0 05 01111111 00 00 00000000 00
09 0 00 00000000 00 00 00123456 00
05 0 05 00000000 00 00 01111111 00

//--- bench/veer_sram_export_tb.sv
// Memory export testbench
// Replays the records of the vector file against the DCCM banks,
// the injection stage and the tag ways, and checks read results.

`default_nettype none

module veer_sram_export_tb;

        timeunit 1ns;
        timeprecision 1ps;

        import dccm_pkg::*;
        import ic_tag_pkg::*;

        localparam int rec_words = 8;
        localparam int max_recs  = 64;

        // operation codes of the vector file
        localparam int op_dccm_wr    = 1;
        localparam int op_dccm_rd    = 2;
        localparam int op_arm        = 3;
        localparam int op_tag_wr     = 4;
        localparam int op_tag_rd     = 5;
        localparam int op_dccm_multi = 6;   // sel is a bank mask
        localparam int op_pending    = 7;
        localparam int op_dccm_hold  = 8;
        localparam int op_tag_hold   = 9;

        typedef struct packed {
                logic [31:0] op;
                logic [31:0] sel;
                logic [31:0] addr;
                logic [31:0] data;
                logic [31:0] ecc;
                logic [31:0] inj;
                logic [31:0] exp_data;
                logic [31:0] exp_ecc;
        } vec_rec_t;

        logic                                clk;
        logic                                reset;
        dccm_bank_mask_t                     dccm_clken;
        dccm_bank_mask_t                     dccm_wren;
        dccm_addr_t [dccm_num_banks-1:0]     dccm_addr_bank;
        dccm_data_t [dccm_num_banks-1:0]     dccm_wr_data_bank;
        dccm_ecc_t  [dccm_num_banks-1:0]     dccm_wr_ecc_bank;
        dccm_data_t [dccm_num_banks-1:0]     dccm_bank_dout;
        dccm_ecc_t  [dccm_num_banks-1:0]     dccm_bank_ecc;
        ic_way_mask_t                        ic_tag_clken;
        ic_way_mask_t                        ic_tag_wren;
        ic_tag_addr_t                        ic_tag_addr;
        ic_tag_t                             ic_tag_wr_data;
        ic_tag_t [ic_num_ways-1:0]           ic_tag_rd_data;
        dccm_inject_t                        dccm_inject;
        logic                                dccm_inject_pending;

        logic [31:0] vec_mem [rec_words*max_recs];
        int          num_recs;
        int          cycle_limit;
        int          cycle_count;

        tb_clock_gen clock_gen_inst (
                .clk   (clk),
                .reset (reset)
        );

        veer_sram_export veer_sram_export_inst (
                .clk                 (clk),
                .reset               (reset),
                .dccm_clken          (dccm_clken),
                .dccm_wren           (dccm_wren),
                .dccm_addr_bank      (dccm_addr_bank),
                .dccm_wr_data_bank   (dccm_wr_data_bank),
                .dccm_wr_ecc_bank    (dccm_wr_ecc_bank),
                .dccm_bank_dout      (dccm_bank_dout),
                .dccm_bank_ecc       (dccm_bank_ecc),
                .ic_tag_clken        (ic_tag_clken),
                .ic_tag_wren         (ic_tag_wren),
                .ic_tag_addr         (ic_tag_addr),
                .ic_tag_wr_data      (ic_tag_wr_data),
                .ic_tag_rd_data      (ic_tag_rd_data),
                .dccm_inject         (dccm_inject),
                .dccm_inject_pending (dccm_inject_pending)
        );

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("Result: FAILED");
                $fatal(1, "run stopped at first error");
        endtask

        task automatic check_dccm_data(input string name, input dccm_data_t got,
                                       input dccm_data_t exp);
                if (got !== exp) begin
                        report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h",
                                                 name, got, exp));
                end
        endtask

        task automatic check_dccm_ecc(input string name, input dccm_ecc_t got,
                                      input dccm_ecc_t exp);
                if (got !== exp) begin
                        report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h",
                                                 name, got, exp));
                end
        endtask

        task automatic check_ic_tag(input string name, input ic_tag_t got, input ic_tag_t exp);
                if (got !== exp) begin
                        report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h",
                                                 name, got, exp));
                end
        endtask

        task automatic check_pending(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h",
                                                 name, got, exp));
                end
        endtask

        task automatic drive_idle();
                dccm_clken        = '0;
                dccm_wren         = '0;
                dccm_addr_bank    = '0;
                dccm_wr_data_bank = '0;
                dccm_wr_ecc_bank  = '0;
                ic_tag_clken      = '0;
                ic_tag_wren       = '0;
                ic_tag_addr       = '0;
                ic_tag_wr_data    = '0;
                dccm_inject       = '0;
        endtask

        task automatic check_bank(input vec_rec_t r);
                int b;
                b = int'(r.sel[1:0]);
                check_dccm_data($sformatf("dccm_bank_dout[%0d]", b), dccm_bank_dout[b],
                                dccm_data_t'(r.exp_data));
                check_dccm_ecc($sformatf("dccm_bank_ecc[%0d]", b), dccm_bank_ecc[b],
                               dccm_ecc_t'(r.exp_ecc));
        endtask

        task automatic check_way(input vec_rec_t r);
                int w;
                w = int'(r.sel[0]);
                check_ic_tag($sformatf("ic_tag_rd_data[%0d]", w), ic_tag_rd_data[w],
                             ic_tag_t'(r.exp_data));
        endtask

        // called on a falling edge, returns on a falling edge
        task automatic run_record(input vec_rec_t r);
                int b;
                int gap;
                b   = int'(r.sel[1:0]);
                gap = int'($urandom % 3);  // idle cycles after the record
                case (r.op)
                        op_dccm_wr, op_dccm_rd, op_dccm_multi: begin
                                for (int i = 0; i < dccm_num_banks; i++) begin
                                        if ((r.op == op_dccm_multi) ? r.sel[i] : (i == b)) begin
                                                dccm_clken[i]        = 1'b1;
                                                dccm_wren[i]         = (r.op != op_dccm_rd);
                                                dccm_addr_bank[i]    = dccm_addr_t'(r.addr);
                                                dccm_wr_data_bank[i] = dccm_data_t'(r.data);
                                                dccm_wr_ecc_bank[i]  = dccm_ecc_t'(r.ecc);
                                        end
                                end
                        end
                        op_arm: dccm_inject = dccm_inject_t'(r.inj[7:0]);
                        op_tag_wr, op_tag_rd: begin
                                ic_tag_clken[r.sel[0]] = 1'b1;
                                ic_tag_wren[r.sel[0]]  = (r.op == op_tag_wr);
                                ic_tag_addr            = ic_tag_addr_t'(r.addr);
                                ic_tag_wr_data         = ic_tag_t'(r.data);
                        end
                        op_pending: check_pending("dccm_inject_pending", dccm_inject_pending,
                                                  r.exp_data[0]);
                        op_dccm_hold: check_bank(r);
                        op_tag_hold: check_way(r);
                        default: report_failure($sformatf("unknown operation code %0d in vectors",
                                                          r.op));
                endcase
                if (r.op < op_pending) begin
                        @(negedge clk);
                        drive_idle();
                end
                if (r.op == op_dccm_rd) begin
                        check_bank(r);
                end
                if (r.op == op_tag_rd) begin
                        check_way(r);
                end
                repeat (gap) @(negedge clk);
        endtask

        always @(posedge clk) begin : watchdog
                cycle_count <= cycle_count + 1;
                if (cycle_limit > 0 && cycle_count > cycle_limit) begin
                        report_failure("timeout: the vectors did not finish in time");
                end
        end

        initial begin : main
                vec_rec_t r;
                int       seed_ret;
                cycle_count = 0;
                cycle_limit = 0;
                drive_idle();
                seed_ret = int'($urandom(20339));
                for (int i = 0; i < rec_words*max_recs; i++) begin
                        vec_mem[i] = 32'hffff_ffff;  // end marker
                end
                $readmemh("bench/sram_vectors.hex", vec_mem);
                num_recs = 0;
                while (num_recs < max_recs && vec_mem[num_recs*rec_words] != 32'hffff_ffff) begin
                        num_recs++;
                end
                if (num_recs == 0) begin
                        report_failure("no records could be read from the vector file");
                end
                cycle_limit = 4 * num_recs + 20;

                wait (reset == 1'b0);
                @(negedge clk);
                for (int n = 0; n < num_recs; n++) begin
                        r = '{op:       vec_mem[n*rec_words],
                              sel:      vec_mem[n*rec_words+1],
                              addr:     vec_mem[n*rec_words+2],
                              data:     vec_mem[n*rec_words+3],
                              ecc:      vec_mem[n*rec_words+4],
                              inj:      vec_mem[n*rec_words+5],
                              exp_data: vec_mem[n*rec_words+6],
                              exp_ecc:  vec_mem[n*rec_words+7]};
                        run_record(r);
                end
                $display("Result: PASSED");
                $finish;
        end

endmodule

`default_nettype wire

//--- bench/veer_sram_export_assertions.sv
// Injection checks for the memory export block
// Pending flag behavior around reset, arm and DCCM writes.

`default_nettype none

module veer_sram_export_assertions (
        input logic                      clk,
        input logic                      reset,
        input dccm_pkg::dccm_bank_mask_t dccm_clken,
        input dccm_pkg::dccm_bank_mask_t dccm_wren,
        input dccm_pkg::dccm_inject_t    dccm_inject,
        input logic                      dccm_inject_pending
);

        timeunit 1ns;
        timeprecision 1ps;

        // low on the cycle after reset
        pending_low_after_reset: assert property (@(posedge clk)
                reset |=> !dccm_inject_pending)
                else $error("inject pending not low after reset");

        // one shot is spent by the first write
        pending_clears_on_write: assert property (@(posedge clk) disable iff (reset)
                (dccm_inject_pending && |(dccm_clken & dccm_wren)) |=> !dccm_inject_pending)
                else $error("inject pending held after a write");

        pending_needs_arm: assert property (@(posedge clk) disable iff (reset)
                (!dccm_inject_pending && !dccm_inject.arm) |=> !dccm_inject_pending)
                else $error("inject pending set without arm");

endmodule

bind veer_sram_export veer_sram_export_assertions assertions_inst (
        .clk                 (clk),
        .reset               (reset),
        .dccm_clken          (dccm_clken),
        .dccm_wren           (dccm_wren),
        .dccm_inject         (dccm_inject),
        .dccm_inject_pending (dccm_inject_pending)
);

`default_nettype wire

//--- bench/tb_clock_gen.sv
// Testbench clock and reset
// 10 ns clock, reset held high over the first two rising edges.

`default_nettype none

module tb_clock_gen (
        output logic clk,
        output logic reset
);

        timeunit 1ns;
        timeprecision 1ps;

        initial begin
                clk   = 1'b0;
                reset = 1'b1;
                forever #5 clk = ~clk;
        end

        initial begin
                repeat (2) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;   // released away from the active edge
        end

endmodule

`default_nettype wire

//--- verilog/veer_sram_export.sv
// Core memory export
// Four DCCM banks storing data with its check bits, a one-shot
// bit-flip stage in the DCCM write path, and one tag RAM per
// instruction cache way. All reads return one cycle after the access.

`default_nettype none

module veer_sram_export (
        input  logic                                                  clk,
        input  logic                                                  reset,

        // DCCM port
        input  dccm_pkg::dccm_bank_mask_t                             dccm_clken,
        input  dccm_pkg::dccm_bank_mask_t                             dccm_wren,
        input  dccm_pkg::dccm_addr_t  [dccm_pkg::dccm_num_banks-1:0] dccm_addr_bank,
        input  dccm_pkg::dccm_data_t  [dccm_pkg::dccm_num_banks-1:0] dccm_wr_data_bank,
        input  dccm_pkg::dccm_ecc_t   [dccm_pkg::dccm_num_banks-1:0] dccm_wr_ecc_bank,
        output dccm_pkg::dccm_data_t  [dccm_pkg::dccm_num_banks-1:0] dccm_bank_dout,
        output dccm_pkg::dccm_ecc_t   [dccm_pkg::dccm_num_banks-1:0] dccm_bank_ecc,

        // instruction cache tag port
        input  ic_tag_pkg::ic_way_mask_t                              ic_tag_clken,
        input  ic_tag_pkg::ic_way_mask_t                              ic_tag_wren,
        input  ic_tag_pkg::ic_tag_addr_t                              ic_tag_addr,
        input  ic_tag_pkg::ic_tag_t                                   ic_tag_wr_data,
        output ic_tag_pkg::ic_tag_t [ic_tag_pkg::ic_num_ways-1:0]     ic_tag_rd_data,

        // error injection control
        input  dccm_pkg::dccm_inject_t                                dccm_inject,
        output logic                                                  dccm_inject_pending
);

        import dccm_pkg::*;
        import ic_tag_pkg::*;

        dccm_bank_mask_t                        dccm_wr_en;    // bank is writing
        dccm_fdata_t [dccm_num_banks-1:0]       dccm_wr_fdata; // {ecc, data} from core
        dccm_fdata_t [dccm_num_banks-1:0]       dccm_wr_fdata_inj;
        dccm_fdata_t [dccm_num_banks-1:0]       dccm_rd_fdata;

        assign dccm_wr_en = dccm_clken & dccm_wren;

        dccm_error_inject dccm_error_inject_inst (
                .clk        (clk),
                .reset      (reset),
                .inject     (dccm_inject),
                .wr_en      (dccm_wr_en),
                .wr_fdata   (dccm_wr_fdata),
                .bank_fdata (dccm_wr_fdata_inj),
                .pending    (dccm_inject_pending)
        );

        for (genvar i = 0; i < dccm_num_banks; i++) begin : dccm_bank
                assign dccm_wr_fdata[i] = {dccm_wr_ecc_bank[i], dccm_wr_data_bank[i]};

                sram_1p #(
                        .depth (dccm_depth),
                        .width (dccm_fdata_w)
                ) dccm_ram (
                        .clk   (clk),
                        .reset (reset),
                        .me    (dccm_clken[i]),
                        .we    (dccm_wren[i]),
                        .adr   (dccm_addr_bank[i]),
                        .d     (dccm_wr_fdata_inj[i]),
                        .q     (dccm_rd_fdata[i])
                );

                assign dccm_bank_dout[i] = dccm_rd_fdata[i][dccm_data_w-1:0];
                assign dccm_bank_ecc[i]  = dccm_rd_fdata[i][dccm_fdata_w-1:dccm_data_w];
        end

        // one tag RAM per way, index shared
        for (genvar w = 0; w < ic_num_ways; w++) begin : ic_tag_way
                sram_1p #(
                        .depth (ic_tag_depth),
                        .width (ic_tag_w)
                ) tag_ram (
                        .clk   (clk),
                        .reset (reset),
                        .me    (ic_tag_clken[w]),
                        .we    (ic_tag_wren[w]),
                        .adr   (ic_tag_addr),
                        .d     (ic_tag_wr_data),
                        .q     (ic_tag_rd_data[w])
                );
        end

endmodule

`default_nettype wire

//--- verilog/dccm_error_inject.sv
// DCCM error injection
// Holds one armed bit-flip request and XORs its mask into the next
// DCCM write word. Only the lowest-numbered writing bank is hit, then
// the request disarms itself. Other banks pass through unchanged.

`default_nettype none

module dccm_error_inject (
        input  logic                                                  clk,
        input  logic                                                  reset,
        input  dccm_pkg::dccm_inject_t                                inject,
        input  dccm_pkg::dccm_bank_mask_t                             wr_en,
        input  dccm_pkg::dccm_fdata_t [dccm_pkg::dccm_num_banks-1:0] wr_fdata,
        output dccm_pkg::dccm_fdata_t [dccm_pkg::dccm_num_banks-1:0] bank_fdata,
        output logic                                                  pending
);

        import dccm_pkg::*;

        logic            pending_q;
        logic            double_q;   // armed mode
        dccm_bit_pos_t   pos_q;      // armed position
        dccm_bit_pos_t   pos_upper;  // second bit of a double flip
        dccm_fdata_t     flip_mask;
        dccm_bank_mask_t target;     // one-hot, lowest writing bank
        logic            any_wr;

        assign any_wr = |wr_en;
        assign target = wr_en & (~wr_en + 1'b1);  // isolate lowest set bit

        // the top bit wraps to bit 0
        assign pos_upper = (pos_q == dccm_bit_pos_t'(dccm_fdata_w - 1)) ?
                           '0 : pos_q + 1'b1;

        always_comb begin : build_mask
                flip_mask = '0;
                flip_mask[pos_q] = 1'b1;
                if (double_q) begin
                        flip_mask[pos_upper] = 1'b1;
                end
        end

        always_comb begin : steer_mask
                for (int i = 0; i < dccm_num_banks; i++) begin
                        if (pending_q && target[i]) begin
                                bank_fdata[i] = wr_fdata[i] ^ flip_mask;
                        end else begin
                                bank_fdata[i] = wr_fdata[i];
                        end
                end
        end

        always_ff @(posedge clk) begin : pending_flag
                if (reset) begin
                        pending_q <= 1'b0;
                end else if (!pending_q) begin
                        pending_q <= inject.arm;  // arm only from idle
                end else if (any_wr) begin
                        pending_q <= 1'b0;        // one shot spent
                end
        end

        always_ff @(posedge clk) begin : capture_request
                if (!pending_q && inject.arm) begin
                        double_q <= inject.double_bit;
                        pos_q    <= inject.bit_pos;
                end
        end

        assign pending = pending_q;

endmodule

`default_nettype wire

//--- verilog/sram_1p.sv
// Generic single-port SRAM
// Synchronous write, registered read with one cycle latency.
// The read register holds its value until the next read.

`default_nettype none

module sram_1p #(
        parameter int depth = 256,
        parameter int width = 39
) (
        input  logic                     clk,
        input  logic                     reset,
        input  logic                     me,   // memory enable
        input  logic                     we,   // write when me is high
        input  logic [$clog2(depth)-1:0] adr,
        input  logic [width-1:0]         d,
        output logic [width-1:0]         q
);

        logic [width-1:0] mem [depth];

        always_ff @(posedge clk) begin : write_port
                if (me && we) begin
                        mem[adr] <= d;
                end
        end

        always_ff @(posedge clk) begin : read_port
                if (reset) begin
                        q <= '0;
                end else if (me && !we) begin
                        q <= mem[adr];  // writes leave q alone
                end
        end

endmodule

`default_nettype wire

//--- verilog/ic_tag_pkg.sv
// Instruction cache tag definitions
// Two ways, one tag RAM per way, index shared by all ways.

`default_nettype none

package ic_tag_pkg;

        localparam int ic_num_ways  = 2;
        localparam int ic_tag_depth = 64;  // entries per way
        localparam int ic_tag_w     = 26;

        typedef logic [$clog2(ic_tag_depth)-1:0] ic_tag_addr_t;
        typedef logic [ic_tag_w-1:0]             ic_tag_t;
        typedef logic [ic_num_ways-1:0]          ic_way_mask_t;

endpackage

`default_nettype wire

//--- verilog/dccm_pkg.sv
// DCCM definitions
// Bank geometry, the stored word layout (check bits above data)
// and the one-shot error injection request.

`default_nettype none

package dccm_pkg;

        localparam int dccm_num_banks = 4;
        localparam int dccm_depth     = 256;                     // words per bank
        localparam int dccm_data_w    = 32;
        localparam int dccm_ecc_w     = 7;
        localparam int dccm_fdata_w   = dccm_data_w + dccm_ecc_w; // {ecc, data}

        typedef logic [$clog2(dccm_depth)-1:0]   dccm_addr_t;
        typedef logic [dccm_data_w-1:0]          dccm_data_t;
        typedef logic [dccm_ecc_w-1:0]           dccm_ecc_t;
        typedef logic [dccm_fdata_w-1:0]         dccm_fdata_t;
        typedef logic [dccm_num_banks-1:0]       dccm_bank_mask_t;
        typedef logic [$clog2(dccm_fdata_w)-1:0] dccm_bit_pos_t;

        // injection request, sampled while no injection is pending
        typedef struct packed {
                logic          arm;        // one-cycle request
                logic          double_bit; // flip bit_pos and the bit above it
                dccm_bit_pos_t bit_pos;    // 0 to dccm_fdata_w-1
        } dccm_inject_t;

endpackage

`default_nettype wire
